/* include/controller_settings.svh */
`ifndef CONTROLLER_SETTINGS_SVH
`define CONTROLLER_SETTINGS_SVH

// Threshold DAC width on the chip
`define DAC_W 10

// Word width toward the USB FIFO
`define DATA_W 16

// External ADC sample width
`define ADC_W 12

// Marks a sweep header word, sits above the DAC value
`define HEADER_TAG 6'b101010

`endif

/* hdl/controllerPkg.sv */
`default_nettype none

package controllerPkg;

    // Operating modes, code 3 decodes as normal acquisition
    typedef enum logic [1:0] {
        MODE_ACQ   = 2'd0,
        MODE_SWEEP = 2'd1,
        MODE_ADC   = 2'd2
    } ctrlMode_t;

    typedef enum logic [2:0] {
        SW_IDLE    = 3'd0,
        SW_LOAD    = 3'd1,
        SW_WAITCFG = 3'd2,
        SW_HEADER  = 3'd3,
        SW_ACQ     = 3'd4,
        SW_NEXT    = 3'd5,
        SW_DONE    = 3'd6
    } sweepState_t;

    typedef enum logic [1:0] {
        AD_IDLE     = 2'd0,
        AD_WAITHOLD = 2'd1,
        AD_DELAY    = 2'd2,
        AD_SAMPLE   = 2'd3
    } adcState_t;

endpackage

`default_nettype wire

/* hdl/engineIf.sv */
`timescale 1ns/10ps
`default_nettype none
`include "controller_settings.svh"

// One test engine toward the mode switcher
interface engineIf;
    logic               start;
    logic [`DATA_W-1:0] data;
    logic               dataEn;
    logic               done;

    modport engine (input start, output data, output dataEn, output done);

    modport switch (output start, input data, input dataEn, input done);

endinterface

`default_nettype wire

/* hdl/modeSwitcher.sv */
`timescale 1ns/10ps
`default_nettype none
`include "controller_settings.svh"

module modeSwitcher (
    input  wire                Clk,
    input  wire                rst,
    input  wire  [1:0]         modeSelect,
    input  wire                startStop,
    input  wire  [`DAC_W-1:0]  usbDac,
    input  wire                usbScLoad,
    input  wire  [`DATA_W-1:0] acqData,
    input  wire                acqDataEn,
    input  wire  [`DAC_W-1:0]  sweepDac,
    input  wire                sweepScLoad,
    input  wire                sweepAcqStartStop,
    engineIf.switch            sweepLink,
    engineIf.switch            adcLink,
    output logic [`DAC_W-1:0]  outDac,
    output logic               outScLoad,
    output logic               acqStartStop,
    output logic [`DATA_W-1:0] fifoData,
    output logic               fifoDataEn,
    output logic               testDone
);
    import controllerPkg::*;

    ctrlMode_t          modeReg;
    ctrlMode_t          reqMode;
    ctrlMode_t          curMode;
    logic               startStopQ;
    logic               runRise;
    logic               selStart;
    logic [`DATA_W-1:0] srcData;
    logic               srcDataEn;
    logic               srcDone;

    ////////////////////////////////////////////////////////////////////////////
    // Mode capture
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (modeSelect)
            MODE_SWEEP: reqMode = MODE_SWEEP;
            MODE_ADC:   reqMode = MODE_ADC;
            default:    reqMode = MODE_ACQ;
        endcase
    end

    assign runRise = startStop & ~startStopQ;
    // Requested mode takes effect in the same cycle as the start edge
    assign curMode = runRise ? reqMode : modeReg;

    always_ff @(posedge Clk) begin
        if (rst) begin
            startStopQ <= 1'b0;
            modeReg    <= MODE_ACQ;
        end else begin
            startStopQ <= startStop;
            if (!startStop) begin
                modeReg <= MODE_ACQ;
            end else begin
                modeReg <= curMode;
            end
        end
    end

    // Only the selected engine sees the run level
    assign sweepLink.start = startStop & (curMode == MODE_SWEEP);
    assign adcLink.start   = startStop & (curMode == MODE_ADC);
    assign selStart = (curMode == MODE_SWEEP) ? sweepLink.start : adcLink.start;

    ////////////////////////////////////////////////////////////////////////////
    // Chip control and data muxes
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (curMode == MODE_SWEEP) begin
            outDac       = sweepDac;
            outScLoad    = sweepScLoad;
            acqStartStop = sweepAcqStartStop;
        end else begin
            outDac       = usbDac;
            outScLoad    = usbScLoad;
            acqStartStop = startStop;
        end
    end

    always_comb begin
        case (curMode)
            MODE_SWEEP: begin
                srcData   = sweepLink.data;
                srcDataEn = sweepLink.dataEn;
                srcDone   = sweepLink.done;
            end
            MODE_ADC: begin
                srcData   = adcLink.data;
                srcDataEn = adcLink.dataEn;
                srcDone   = adcLink.done;
            end
            default: begin
                srcData   = acqData;
                srcDataEn = acqDataEn;
                srcDone   = 1'b0;
            end
        endcase
    end

    // Word payload
    always_ff @(posedge Clk) begin
        fifoData <= srcData;
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            fifoDataEn <= 1'b0;
            testDone   <= 1'b0;
        end else begin
            fifoDataEn <= srcDataEn;
            testDone   <= srcDone;
        end
    end

    // An engine only writes the FIFO while it is running
    assert property (@(posedge Clk) disable iff (rst)
        ($rose(fifoDataEn) && ($past(curMode) != MODE_ACQ)) |-> $past(selStart))
        else $error("FIFO write from an engine that was not started");

endmodule

`default_nettype wire

/* hdl/sweepAcq.sv */
`timescale 1ns/10ps
`default_nettype none
`include "controller_settings.svh"

module sweepAcq (
    input  wire                Clk,
    input  wire                rst,
    engineIf.engine            link,
    input  wire  [`DAC_W-1:0]  startDac,
    input  wire  [`DAC_W-1:0]  endDac,
    input  wire  [15:0]        maxPackageNumber,
    input  wire                configDone,
    input  wire  [`DATA_W-1:0] acqData,
    input  wire                acqDataEn,
    input  wire                usbFifoFull,
    output logic [`DAC_W-1:0]  dac,
    output logic               scLoad,
    output logic               acqStartStop
);
    import controllerPkg::*;

    sweepState_t        state;
    logic               startQ;
    logic [`DAC_W-1:0]  lastDac;
    logic [15:0]        pkgCount;
    logic [`DATA_W-1:0] dataQ;
    logic               dataEnQ;
    logic               done;

    // A reversed range collapses to one step
    assign lastDac = (endDac < startDac) ? startDac : endDac;

    ////////////////////////////////////////////////////////////////////////////
    // Sweep sequencer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (rst) begin
            state    <= SW_IDLE;
            startQ   <= 1'b0;
            dac      <= '0;
            scLoad   <= 1'b0;
            pkgCount <= '0;
            dataEnQ  <= 1'b0;
            done     <= 1'b0;
        end else begin
            startQ  <= link.start;
            scLoad  <= 1'b0;
            dataEnQ <= 1'b0;
            done    <= 1'b0;
            if (!link.start) begin
                // Abort, no done
                state <= SW_IDLE;
            end else begin
                case (state)
                    SW_IDLE: begin
                        if (!startQ) begin
                            dac   <= startDac;
                            state <= SW_LOAD;
                        end
                    end
                    SW_LOAD: begin
                        scLoad <= 1'b1;
                        state  <= SW_WAITCFG;
                    end
                    SW_WAITCFG: begin
                        if (configDone) begin
                            state <= SW_HEADER;
                        end
                    end
                    SW_HEADER: begin
                        dataEnQ  <= 1'b1;
                        pkgCount <= '0;
                        state    <= (maxPackageNumber == 16'd0) ? SW_NEXT : SW_ACQ;
                    end
                    SW_ACQ: begin
                        if (acqDataEn) begin
                            dataEnQ  <= 1'b1;
                            pkgCount <= pkgCount + 16'd1;
                            if (pkgCount + 16'd1 == maxPackageNumber) begin
                                state <= SW_NEXT;
                            end
                        end
                    end
                    SW_NEXT: begin
                        if (dac == lastDac) begin
                            done  <= 1'b1;
                            state <= SW_DONE;
                        end else begin
                            dac   <= dac + 1'b1;
                            state <= SW_LOAD;
                        end
                    end
                    // Start is still high here, so idle does not rearm
                    SW_DONE: state <= SW_IDLE;
                    default: state <= SW_IDLE;
                endcase
            end
        end
    end

    // Header word or the chip word of the previous cycle
    always_ff @(posedge Clk) begin
        if (state == SW_HEADER) begin
            dataQ <= {`HEADER_TAG, dac};
        end else if (acqDataEn) begin
            dataQ <= acqData;
        end
    end

    // Chip is paused while the USB FIFO is full
    assign acqStartStop = (state == SW_ACQ) & ~usbFifoFull;

    assign link.data   = dataQ;
    assign link.dataEn = dataEnQ;
    assign link.done   = done;

    assert property (@(posedge Clk) disable iff (rst) scLoad |=> !scLoad)
        else $error("Slow control load held for two cycles");

    assert property (@(posedge Clk) disable iff (rst)
        (state != SW_IDLE) |-> ((dac >= startDac) && (dac <= lastDac)))
        else $error("Sweep DAC outside its range");

endmodule

`default_nettype wire

/* hdl/adcControl.sv */
`timescale 1ns/10ps
`default_nettype none
`include "controller_settings.svh"

module adcControl (
    input  wire               Clk,
    input  wire               rst,
    engineIf.engine           link,
    input  wire               hold,
    input  wire  [3:0]        adcStartDelay,
    input  wire  [7:0]        adcDataNumber,
    input  wire  [`ADC_W-1:0] adcData,
    input  wire               adcOtr,
    output logic              adcClk
);
    import controllerPkg::*;

    adcState_t          state;
    logic               holdQ;
    logic               holdRise;
    logic [3:0]         delayCnt;
    logic [7:0]         sampleCnt;
    logic [`DATA_W-1:0] dataQ;
    logic               dataEnQ;
    logic               lastWord;
    logic               done;

    assign holdRise = hold & ~holdQ;

    always_ff @(posedge Clk) begin
        if (rst) begin
            state     <= AD_IDLE;
            holdQ     <= 1'b0;
            delayCnt  <= '0;
            sampleCnt <= '0;
            adcClk    <= 1'b0;
            dataEnQ   <= 1'b0;
            lastWord  <= 1'b0;
            done      <= 1'b0;
        end else begin
            holdQ    <= hold;
            dataEnQ  <= 1'b0;
            lastWord <= 1'b0;
            // Done trails the last word by one cycle
            done     <= lastWord & link.start;
            if (!link.start) begin
                state  <= AD_IDLE;
                adcClk <= 1'b0;
            end else begin
                case (state)
                    AD_IDLE: state <= AD_WAITHOLD;
                    AD_WAITHOLD: begin
                        if (holdRise) begin
                            sampleCnt <= '0;
                            if (adcStartDelay == 4'd0) begin
                                state <= AD_SAMPLE;
                            end else begin
                                delayCnt <= adcStartDelay - 4'd1;
                                state    <= AD_DELAY;
                            end
                        end
                    end
                    AD_DELAY: begin
                        if (delayCnt == 4'd0) begin
                            state <= AD_SAMPLE;
                        end else begin
                            delayCnt <= delayCnt - 4'd1;
                        end
                    end
                    AD_SAMPLE: begin
                        if (adcDataNumber == 8'd0) begin
                            lastWord <= 1'b1;
                            state    <= AD_WAITHOLD;
                        end else if (!adcClk) begin
                            adcClk <= 1'b1;
                        end else begin
                            // Sample taken at the end of the high phase
                            adcClk    <= 1'b0;
                            dataEnQ   <= 1'b1;
                            sampleCnt <= sampleCnt + 8'd1;
                            if (sampleCnt + 8'd1 == adcDataNumber) begin
                                lastWord <= 1'b1;
                                state    <= AD_WAITHOLD;
                            end
                        end
                    end
                    default: state <= AD_IDLE;
                endcase
            end
        end
    end

    // Out of range flag on top then three zero bits
    always_ff @(posedge Clk) begin
        if ((state == AD_SAMPLE) && adcClk) begin
            dataQ <= {adcOtr, 3'b000, adcData};
        end
    end

    assign link.data   = dataQ;
    assign link.dataEn = dataEnQ;
    assign link.done   = done;

    assert property (@(posedge Clk) disable iff (rst) (state != AD_SAMPLE) |-> !adcClk)
        else $error("ADC clock running outside a burst");

endmodule

`default_nettype wire

/* hdl/controllerTop.sv */
`timescale 1ns/10ps
`default_nettype none
`include "controller_settings.svh"

module controllerTop (
    input  wire                Clk,
    input  wire                rst,
    input  wire  [1:0]         modeSelect,
    input  wire                startStop,
    input  wire  [`DAC_W-1:0]  usbDac,
    input  wire                usbScLoad,
    input  wire                configDone,
    input  wire  [`DATA_W-1:0] acqData,
    input  wire                acqDataEn,
    input  wire                usbFifoFull,
    input  wire  [`DAC_W-1:0]  startDac,
    input  wire  [`DAC_W-1:0]  endDac,
    input  wire  [15:0]        maxPackageNumber,
    input  wire                hold,
    input  wire  [3:0]         adcStartDelay,
    input  wire  [7:0]         adcDataNumber,
    input  wire  [`ADC_W-1:0]  adcData,
    input  wire                adcOtr,
    output logic [`DAC_W-1:0]  outDac,
    output logic               outScLoad,
    output logic               acqStartStop,
    output logic               adcClk,
    output logic [`DATA_W-1:0] fifoData,
    output logic               fifoDataEn,
    output logic               testDone
);
    logic [`DAC_W-1:0] sweepDac;
    logic              sweepScLoad;
    logic              sweepAcqStartStop;

    engineIf sweepLink ();
    engineIf adcLink ();

    modeSwitcher u_switcher (
        .Clk               (Clk),
        .rst               (rst),
        .modeSelect        (modeSelect),
        .startStop         (startStop),
        .usbDac            (usbDac),
        .usbScLoad         (usbScLoad),
        .acqData           (acqData),
        .acqDataEn         (acqDataEn),
        .sweepDac          (sweepDac),
        .sweepScLoad       (sweepScLoad),
        .sweepAcqStartStop (sweepAcqStartStop),
        .sweepLink         (sweepLink.switch),
        .adcLink           (adcLink.switch),
        .outDac            (outDac),
        .outScLoad         (outScLoad),
        .acqStartStop      (acqStartStop),
        .fifoData          (fifoData),
        .fifoDataEn        (fifoDataEn),
        .testDone          (testDone)
    );

    // DAC sweep engine
    sweepAcq u_sweep (
        .Clk              (Clk),
        .rst              (rst),
        .link             (sweepLink.engine),
        .startDac         (startDac),
        .endDac           (endDac),
        .maxPackageNumber (maxPackageNumber),
        .configDone       (configDone),
        .acqData          (acqData),
        .acqDataEn        (acqDataEn),
        .usbFifoFull      (usbFifoFull),
        .dac              (sweepDac),
        .scLoad           (sweepScLoad),
        .acqStartStop     (sweepAcqStartStop)
    );

    // External ADC readout
    adcControl u_adc (
        .Clk           (Clk),
        .rst           (rst),
        .link          (adcLink.engine),
        .hold          (hold),
        .adcStartDelay (adcStartDelay),
        .adcDataNumber (adcDataNumber),
        .adcData       (adcData),
        .adcOtr        (adcOtr),
        .adcClk        (adcClk)
    );

endmodule

`default_nettype wire

/* tb/controllerTb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "controller_settings.svh"

module controllerTb;
    import controllerPkg::*;

    logic               Clk;
    logic               rst;
    logic [1:0]         modeSelect;
    logic               startStop;
    logic [`DAC_W-1:0]  usbDac;
    logic               usbScLoad;
    logic               configDone;
    logic [`DATA_W-1:0] acqData;
    logic               acqDataEn;
    logic               usbFifoFull;
    logic [`DAC_W-1:0]  startDac;
    logic [`DAC_W-1:0]  endDac;
    logic [15:0]        maxPackageNumber;
    logic               hold;
    logic [3:0]         adcStartDelay;
    logic [7:0]         adcDataNumber;
    logic [`ADC_W-1:0]  adcData;
    logic               adcOtr;
    logic [`DAC_W-1:0]  outDac;
    logic               outScLoad;
    logic               acqStartStop;
    logic               adcClk;
    logic [`DATA_W-1:0] fifoData;
    logic               fifoDataEn;
    logic               testDone;

    integer             seed = 98038;
    logic [`DATA_W-1:0] chipQ[$];
    logic [12:0]        adcQ[$];
    ctrlMode_t          expMode;
    int                 sDac;
    int                 eDac;
    int                 mPkg;
    int                 wordIdx;
    int                 doneCount;
    int                 scLoadCount;
    int                 errors;
    int                 testsRun;
    int                 testsFailed;
    int                 cycles;
    logic [2:0]         cfgPipe;
    int                 chipDiv;
    logic               chipFire;
    logic [`DATA_W-1:0] chipWord;
    logic               fullRandom;
    logic               fullOn;
    logic [31:0]        fullRnd;
    logic [31:0]        adcRnd;
    logic               lastAcqEn;
    logic [`DATA_W-1:0] lastAcqData;
    logic [`DATA_W-1:0] expWord;
    logic               hasWord;

    controllerTop u_dut (
        .Clk (Clk), .rst (rst), .modeSelect (modeSelect), .startStop (startStop),
        .usbDac (usbDac), .usbScLoad (usbScLoad), .configDone (configDone),
        .acqData (acqData), .acqDataEn (acqDataEn), .usbFifoFull (usbFifoFull),
        .startDac (startDac), .endDac (endDac), .maxPackageNumber (maxPackageNumber),
        .hold (hold), .adcStartDelay (adcStartDelay), .adcDataNumber (adcDataNumber),
        .adcData (adcData), .adcOtr (adcOtr), .outDac (outDac), .outScLoad (outScLoad),
        .acqStartStop (acqStartStop), .adcClk (adcClk), .fifoData (fifoData),
        .fifoDataEn (fifoDataEn), .testDone (testDone)
    );

    initial begin
        Clk = 1'b0;
        forever #10 Clk = ~Clk;
    end

    always @(posedge Clk) begin
        cycles++;
        if (cycles >= 20000) begin
            $display("Run stopped: the cycle limit of 20000 was reached before the tests ended");
            $display("STATUS: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Chip and ADC models
    ////////////////////////////////////////////////////////////////////////////

    // Config done 3 cycles after each load, one word per 4 running cycles
    always @(posedge Clk) begin
        chipFire = 1'b0;
        if (rst) begin
            chipDiv = 0;
            cfgPipe = '0;
        end else begin
            cfgPipe = {cfgPipe[1:0], outScLoad};
            if (acqStartStop) begin
                if (chipDiv == 3) begin
                    chipDiv  = 0;
                    chipFire = 1'b1;
                end else begin
                    chipDiv++;
                end
            end
        end
        #2;
        configDone = cfgPipe[2];
        acqDataEn  = chipFire;
        if (chipFire) begin
            acqData = chipWord;
            chipQ.push_back(chipWord);
            chipWord++;
        end
    end

    always @(posedge adcClk) begin
        #2;
        adcRnd  = $random(seed);
        adcData = adcRnd[11:0];
        adcOtr  = adcRnd[12];
        adcQ.push_back(adcRnd[12:0]);
    end

    // FIFO full noise for the back-pressure test
    always @(posedge Clk) begin
        fullOn = fullRandom;
        #2;
        if (fullOn) begin
            fullRnd     = $random(seed);
            usbFifoFull = fullRnd[0];
        end else begin
            usbFifoFull = 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference and compare
    ////////////////////////////////////////////////////////////////////////////

    // Expected FIFO word at a position of the current test's stream
    function automatic bit refWord(input int idx, output logic [`DATA_W-1:0] word);
        int                grp;
        int                pos;
        int                ci;
        logic [`DAC_W-1:0] dacVal;
        word    = '0;
        refWord = 1'b0;
        case (expMode)
            MODE_SWEEP: begin
                grp    = idx / (mPkg + 1);
                pos    = idx % (mPkg + 1);
                ci     = grp * mPkg + pos - 1;
                dacVal = sDac + grp;
                if (grp <= eDac - sDac) begin
                    if (pos == 0) begin
                        word    = {`HEADER_TAG, dacVal};
                        refWord = 1'b1;
                    end else if (ci < chipQ.size()) begin
                        word    = chipQ[ci];
                        refWord = 1'b1;
                    end
                end
            end
            MODE_ADC: begin
                if (idx < adcQ.size()) begin
                    word    = {adcQ[idx][12], 3'b000, adcQ[idx][11:0]};
                    refWord = 1'b1;
                end
            end
            default: begin
                if (idx < chipQ.size()) begin
                    word    = chipQ[idx];
                    refWord = 1'b1;
                end
            end
        endcase
    endfunction

    always @(posedge Clk) begin
        if (!rst) begin
            if (testDone) doneCount++;
            if (outScLoad) scLoadCount++;
            if (acqStartStop && usbFifoFull) begin
                errors++;
                $display("FAILED at %0t: acqStartStop high while usbFifoFull is high", $time);
            end
            if (fifoDataEn) begin
                hasWord = refWord(wordIdx, expWord);
                if (!hasWord) begin
                    errors++;
                    $display("FAILED at %0t: extra word %h at index %0d", $time, fifoData,
                             wordIdx);
                end else if (fifoData !== expWord) begin
                    errors++;
                    $display("FAILED at %0t: word %0d is %h, expected %h", $time, wordIdx,
                             fifoData, expWord);
                end
                // Normal mode is a plain one-cycle pipe
                if (expMode == MODE_ACQ && (!lastAcqEn || fifoData !== lastAcqData)) begin
                    errors++;
                    $display("FAILED at %0t: word %h not one cycle after acqData", $time,
                             fifoData);
                end
                wordIdx++;
            end
        end
        lastAcqEn   = acqDataEn;
        lastAcqData = acqData;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic stepCycles(input int n);
        repeat (n) @(posedge Clk);
        #2;
    endtask

    task automatic clearStream(input ctrlMode_t mode);
        chipQ.delete();
        adcQ.delete();
        expMode     = mode;
        wordIdx     = 0;
        doneCount   = 0;
        scLoadCount = 0;
    endtask

    task automatic waitForDone(input int target, input string name);
        int waited;
        waited = 0;
        while (doneCount < target && waited < 2000) begin
            stepCycles(1);
            waited++;
        end
        if (doneCount < target) begin
            errors++;
            $display("Test %s: testDone did not arrive within 2000 cycles", name);
        end
    endtask

    task automatic checkCount(input int got, input int want, input string what);
        if (got != want) begin
            errors++;
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    task automatic reportTest(input int num, input string name, input int errBefore);
        testsRun++;
        if (errors > errBefore) begin
            testsFailed++;
            $display("Test %0d %s: failed", num, name);
        end else begin
            $display("Test %0d %s: passed", num, name);
        end
    endtask

    task automatic runNormal();
        int errBefore;
        errBefore = errors;
        clearStream(MODE_ACQ);
        modeSelect = 2'd0;
        usbDac     = 10'h2A5;
        startStop  = 1'b1;
        stepCycles(40);
        if (outDac !== usbDac) begin
            errors++;
            $display("FAILED at %0t: outDac %h, expected %h", $time, outDac, usbDac);
        end
        startStop = 1'b0;
        stepCycles(6);
        checkCount(wordIdx, chipQ.size(), "normal mode word count");
        if (chipQ.size() == 0) begin
            errors++;
            $display("Test 2: the chip model produced no words in normal mode");
        end
        reportTest(2, "normal mode", errBefore);
    endtask

    task automatic runSweep(input int num, input string name, input bit noisy,
                            input bit switchMode);
        int errBefore;
        errBefore = errors;
        clearStream(MODE_SWEEP);
        sDac             = 5;
        eDac             = 8;
        mPkg             = 3;
        startDac         = 10'd5;
        endDac           = 10'd8;
        maxPackageNumber = 16'd3;
        modeSelect       = 2'd1;
        fullRandom       = noisy;
        startStop        = 1'b1;
        if (switchMode) begin
            stepCycles(30);
            modeSelect = 2'd2;
            stepCycles(20);
            modeSelect = 2'd0;
        end
        waitForDone(1, name);
        stepCycles(5);
        fullRandom = 1'b0;
        startStop  = 1'b0;
        stepCycles(5);
        checkCount(wordIdx, (eDac - sDac + 1) * (mPkg + 1), "sweep word count");
        checkCount(doneCount, 1, "testDone count");
        checkCount(scLoadCount, eDac - sDac + 1, "outScLoad pulse count");
        reportTest(num, name, errBefore);
    endtask

    task automatic runAdc();
        int errBefore;
        errBefore = errors;
        clearStream(MODE_ADC);
        adcStartDelay = 4'd3;
        adcDataNumber = 8'd6;
        modeSelect    = 2'd2;
        startStop     = 1'b1;
        stepCycles(4);
        for (int burst = 1; burst <= 2; burst++) begin
            hold = 1'b1;
            stepCycles(3);
            hold = 1'b0;
            waitForDone(burst, "ADC readout");
            checkCount(wordIdx, 6 * burst, "ADC word count");
            stepCycles(4);
        end
        startStop = 1'b0;
        stepCycles(5);
        checkCount(doneCount, 2, "testDone count");
        reportTest(5, "ADC readout", errBefore);
    endtask

    initial begin
        int errBefore;
        rst = 1'b1;
        modeSelect = 2'd0;
        startStop = 1'b0;
        usbDac = '0;
        usbScLoad = 1'b0;
        configDone = 1'b0;
        acqData = '0;
        acqDataEn = 1'b0;
        usbFifoFull = 1'b0;
        startDac = '0;
        endDac = '0;
        maxPackageNumber = '0;
        hold = 1'b0;
        adcStartDelay = '0;
        adcDataNumber = '0;
        adcData = '0;
        adcOtr = 1'b0;
        fullRandom = 1'b0;
        chipWord = 16'h0100;
        expMode = MODE_ACQ;
        errors = 0;
        testsRun = 0;
        testsFailed = 0;
        cycles = 0;
        repeat (10) @(posedge Clk);
        #2 rst = 1'b0;

        errBefore = errors;
        if (fifoDataEn !== 1'b0 || testDone !== 1'b0 || outScLoad !== 1'b0 ||
            acqStartStop !== 1'b0 || adcClk !== 1'b0) begin
            errors++;
            $display("FAILED at %0t: outputs after reset %b%b%b%b%b, expected 00000", $time,
                     fifoDataEn, testDone, outScLoad, acqStartStop, adcClk);
        end
        reportTest(1, "reset values", errBefore);

        runNormal();
        runSweep(3, "DAC sweep", 1'b0, 1'b0);
        runSweep(4, "sweep with FIFO full", 1'b1, 1'b0);
        runAdc();
        runSweep(6, "mode change during sweep", 1'b0, 1'b1);

        $display("Tests run: %0d, failed: %0d, errors: %0d", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+include
hdl/controllerPkg.sv
hdl/engineIf.sv
hdl/modeSwitcher.sv
hdl/sweepAcq.sv
hdl/adcControl.sv
hdl/controllerTop.sv
tb/controllerTb.sv
